/* rtl/tinker_settings.svh */
// Tinker width, register count, memory size, reset PC and stack-top macros
`ifndef TINKER_SETTINGS_SVH
`define TINKER_SETTINGS_SVH

// Datapath, instruction and address widths
`define TINKER_XLEN      64
`define TINKER_ILEN      32
`define TINKER_ALEN      32

// Architectural registers, r31 is the stack pointer
`define TINKER_NREGS     32

// 512 KiB of byte-addressed memory
`define TINKER_MEM_BYTES 524288

// First instruction after reset
`define TINKER_RESET_PC  32'h2000

// Stack starts one past the last byte of memory
`define TINKER_STACK_TOP `TINKER_MEM_BYTES

`endif

/* rtl/tinker_pkg.sv */
// Tinker opcode, FSM state, instruction, memory request, register write and memory word types
`include "tinker_settings.svh"

package tinker_pkg;

    typedef logic [$clog2(`TINKER_NREGS)-1:0] reg_addr_t;

    typedef enum logic [4:0] {
        OP_AND    = 5'h00,
        OP_OR     = 5'h01,
        OP_XOR    = 5'h02,
        OP_NOT    = 5'h03,
        OP_SHFTR  = 5'h04,
        OP_SHFTRI = 5'h05,
        OP_SHFTL  = 5'h06,
        OP_SHFTLI = 5'h07,
        OP_BR     = 5'h08,
        OP_BRR_R  = 5'h09, // PC relative, offset in rd
        OP_BRR_L  = 5'h0A, // PC relative, offset in literal
        OP_BRNZ   = 5'h0B,
        OP_BRGT   = 5'h0E,
        OP_HALT   = 5'h0F,
        OP_LOAD   = 5'h10, // rd <- mem[rs + L]
        OP_MOV    = 5'h11,
        OP_MOVL   = 5'h12,
        OP_STORE  = 5'h13, // mem[rd + L] <- rs
        OP_ADD    = 5'h18,
        OP_ADDI   = 5'h19,
        OP_SUB    = 5'h1A,
        OP_SUBI   = 5'h1B,
        OP_MUL    = 5'h1C
    } opcode_e;

    typedef struct packed {
        opcode_e     opcode; // [31:27]
        reg_addr_t   rd;     // [26:22]
        reg_addr_t   rs;     // [21:17]
        reg_addr_t   rt;     // [16:12]
        logic [11:0] lit;
    } instr_t;

    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        FETCH     = 3'd1,
        DECODE    = 3'd2,
        EXECUTE   = 3'd3,
        MEMORY    = 3'd4,
        WRITEBACK = 3'd5,
        HALTED    = 3'd6
    } fsm_state_e;

    // Core data port into memory
    typedef struct packed {
        logic                    we;
        logic [`TINKER_ALEN-1:0] addr;
        logic [`TINKER_XLEN-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic                    en;
        reg_addr_t               addr;
        logic [`TINKER_XLEN-1:0] data;
    } rf_write_t;

    // Lane 0 is the byte at the lowest address
    typedef union packed {
        logic [`TINKER_XLEN-1:0]          value;
        logic [`TINKER_XLEN/8-1:0][7:0]   lane;
    } mem_word_u;

endpackage

/* rtl/tinker_alu.sv */
// Tinker integer ALU for arithmetic, logic, shift and move-literal opcodes
`timescale 1ns/100ps
`include "tinker_settings.svh"

module tinker_alu import tinker_pkg::*; (
    input  opcode_e                 opcode,
    input  logic [`TINKER_XLEN-1:0] op1,    // rd for immediate forms, rs otherwise
    input  logic [`TINKER_XLEN-1:0] op2,    // rt
    input  logic [11:0]             lit,
    output logic [`TINKER_XLEN-1:0] result
);

    logic [`TINKER_XLEN-1:0] lit_sext;
    logic [`TINKER_XLEN-1:0] lit_zext;

    assign lit_sext = {{(`TINKER_XLEN-12){lit[11]}}, lit};
    assign lit_zext = {{(`TINKER_XLEN-12){1'b0}}, lit};

    always_comb begin
        case (opcode)
            // Arithmetic
            OP_ADD:    result = op1 + op2;
            OP_ADDI:   result = op1 + lit_sext;
            OP_SUB:    result = op1 - op2;
            OP_SUBI:   result = op1 - lit_zext;   // Unsigned literal here
            OP_MUL:    result = op1 * op2;        // Low 64 bits of the product

            // Logic
            OP_AND:    result = op1 & op2;
            OP_OR:     result = op1 | op2;
            OP_XOR:    result = op1 ^ op2;
            OP_NOT:    result = ~op1;             // rt ignored

            // Logical shifts
            OP_SHFTR:  result = op1 >> op2;
            OP_SHFTRI: result = op1 >> lit;
            OP_SHFTL:  result = op1 << op2;
            OP_SHFTLI: result = op1 << lit;

            // Only the low 12 bits of rd change
            OP_MOVL:   result = {op1[`TINKER_XLEN-1:12], lit};

            default:   result = '0;
        endcase
    end

endmodule

/* rtl/tinker_regfile.sv */
// Tinker register file, 32 x 64 bits, three read ports and one write port
`timescale 1ns/100ps
`include "tinker_settings.svh"

module tinker_regfile import tinker_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  rf_write_t               wr,
    input  reg_addr_t               rd_addr,
    input  reg_addr_t               rs_addr,
    input  reg_addr_t               rt_addr,
    output logic [`TINKER_XLEN-1:0] rd_data,
    output logic [`TINKER_XLEN-1:0] rs_data,
    output logic [`TINKER_XLEN-1:0] rt_data
);

    logic [`TINKER_XLEN-1:0] regs [`TINKER_NREGS];

    // r0 is an ordinary register in this ISA
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `TINKER_NREGS - 1; i++) begin
                regs[i] <= '0;
            end
            regs[`TINKER_NREGS-1] <= `TINKER_XLEN'(`TINKER_STACK_TOP); // Stack pointer
        end else if (wr.en) begin
            regs[wr.addr] <= wr.data;
        end
    end

    // Combinational reads
    assign rd_data = regs[rd_addr];
    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];

endmodule

/* rtl/tinker_memory.sv */
// Tinker byte-addressed little-endian memory with fetch, data and host ports
`timescale 1ns/100ps
`include "tinker_settings.svh"

module tinker_memory import tinker_pkg::*; (
    input  logic                    clk,
    input  logic [`TINKER_ALEN-1:0] fetch_addr,
    output logic [`TINKER_ILEN-1:0] fetch_data,
    input  mem_req_t                data_req,
    output logic [`TINKER_XLEN-1:0] data_rdata,
    input  logic                    host_we,
    input  logic [`TINKER_ALEN-1:0] host_addr,
    input  logic [`TINKER_XLEN-1:0] host_wdata,
    output logic [`TINKER_XLEN-1:0] host_rdata
);

    localparam int unsigned IDX_W       = $clog2(`TINKER_MEM_BYTES);
    localparam int unsigned WORD_BYTES  = `TINKER_XLEN / 8;
    localparam int unsigned INSTR_BYTES = `TINKER_ILEN / 8;

    typedef logic [IDX_W-1:0] idx_t;

    logic [7:0] mem [`TINKER_MEM_BYTES];

    logic [INSTR_BYTES-1:0][7:0] fetch_bytes;
    mem_word_u                   data_word;
    mem_word_u                   host_word;
    mem_word_u                   wr_word;
    logic [`TINKER_ALEN-1:0]     wr_addr;
    logic                        wr_en;

    // Reads wrap at the top of memory
    always_comb begin
        for (int i = 0; i < INSTR_BYTES; i++) begin
            fetch_bytes[i] = mem[idx_t'(fetch_addr + i)];
        end
        for (int i = 0; i < WORD_BYTES; i++) begin
            data_word.lane[i] = mem[idx_t'(data_req.addr + i)];
            host_word.lane[i] = mem[idx_t'(host_addr + i)];
        end
    end

    assign fetch_data = fetch_bytes;
    assign data_rdata = data_word.value;
    assign host_rdata = host_word.value;

    // Single write port, host has priority over the core
    assign wr_en         = host_we | data_req.we;
    assign wr_addr       = host_we ? host_addr : data_req.addr;
    assign wr_word.value = host_we ? host_wdata : data_req.wdata;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < WORD_BYTES; i++) begin
                mem[idx_t'(wr_addr + i)] <= wr_word.lane[i]; // LSB to lowest address
            end
        end
    end

endmodule

/* rtl/tinker_control.sv */
// Tinker control unit with FSM, PC, instruction and result registers, branches and load/store
`timescale 1ns/100ps
`include "tinker_settings.svh"

module tinker_control import tinker_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    run,
    output logic [`TINKER_ALEN-1:0] fetch_addr,
    input  logic [`TINKER_ILEN-1:0] fetch_data,
    output reg_addr_t               rd_addr,
    output reg_addr_t               rs_addr,
    output reg_addr_t               rt_addr,
    input  logic [`TINKER_XLEN-1:0] rd_data,
    input  logic [`TINKER_XLEN-1:0] rs_data,
    input  logic [`TINKER_XLEN-1:0] rt_data,
    output mem_req_t                data_req,
    input  logic [`TINKER_XLEN-1:0] data_rdata,
    output rf_write_t               rf_wr,
    output logic                    hlt
);

    fsm_state_e              state;
    fsm_state_e              state_next;
    logic [`TINKER_ALEN-1:0] pc;
    logic [`TINKER_ALEN-1:0] pc_next;       // Captured in MEMORY
    logic [`TINKER_ALEN-1:0] pc_plus4;
    logic [`TINKER_ALEN-1:0] branch_target;
    logic [`TINKER_ALEN-1:0] lit_zext;
    logic [`TINKER_ALEN-1:0] lit_sext;
    logic [`TINKER_ALEN-1:0] mem_base;
    instr_t                  ir;
    logic [`TINKER_XLEN-1:0] result;
    logic [`TINKER_XLEN-1:0] alu_op1;
    logic [`TINKER_XLEN-1:0] alu_result;
    logic                    imm_form;
    logic                    writes_reg;

    assign imm_form   = ir.opcode inside {OP_ADDI, OP_SUBI, OP_SHFTRI, OP_SHFTLI, OP_MOVL};
    assign writes_reg = ir.opcode inside {[OP_AND:OP_SHFTLI], [OP_LOAD:OP_MOVL], [OP_ADD:OP_MUL]};
    assign alu_op1    = imm_form ? rd_data : rs_data;

    tinker_alu tinker_alu_inst (
        .opcode (ir.opcode),
        .op1    (alu_op1),
        .op2    (rt_data),
        .lit    (ir.lit),
        .result (alu_result)
    );

    // One cycle per state, halt is caught in DECODE
    always_comb begin
        case (state)
            IDLE:      state_next = run ? FETCH : IDLE;
            FETCH:     state_next = DECODE;
            DECODE:    state_next = (ir.opcode == OP_HALT) ? HALTED : EXECUTE;
            EXECUTE:   state_next = MEMORY;
            MEMORY:    state_next = WRITEBACK;
            WRITEBACK: state_next = FETCH;
            HALTED:    state_next = HALTED;     // Only reset leaves
            default:   state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= IDLE;
            pc    <= `TINKER_RESET_PC;
        end else begin
            state <= state_next;
            if (state == WRITEBACK) begin
                pc <= pc_next;
            end
        end
    end

    // Instruction, result and next-PC registers
    always_ff @(posedge clk) begin
        case (state)
            FETCH:   ir <= instr_t'(fetch_data);
            EXECUTE: result <= (ir.opcode == OP_MOV) ? rs_data : alu_result;
            MEMORY: begin
                pc_next <= branch_target;
                if (ir.opcode == OP_LOAD) begin
                    result <= data_rdata;
                end
            end
            default: ;
        endcase
    end

    assign pc_plus4 = pc + `TINKER_ALEN'(4);
    assign lit_zext = {{(`TINKER_ALEN-12){1'b0}}, ir.lit};
    assign lit_sext = {{(`TINKER_ALEN-12){ir.lit[11]}}, ir.lit};

    always_comb begin
        case (ir.opcode)
            OP_BR:    branch_target = rd_data[`TINKER_ALEN-1:0];
            OP_BRR_R: branch_target = pc + rd_data[`TINKER_ALEN-1:0];
            OP_BRR_L: branch_target = pc + lit_sext;
            OP_BRNZ:  branch_target = (rs_data != '0) ? rd_data[`TINKER_ALEN-1:0] : pc_plus4;
            OP_BRGT: begin
                // Signed compare of rs against rt
                if ($signed(rs_data) > $signed(rt_data)) begin
                    branch_target = rd_data[`TINKER_ALEN-1:0];
                end else begin
                    branch_target = pc_plus4;
                end
            end
            default:  branch_target = pc_plus4;
        endcase
    end

    // Store uses rd as base, load uses rs
    assign mem_base = (ir.opcode == OP_STORE) ? rd_data[`TINKER_ALEN-1:0]
                                              : rs_data[`TINKER_ALEN-1:0];

    always_comb begin
        data_req.we    = (state == MEMORY) && (ir.opcode == OP_STORE);
        data_req.addr  = mem_base + lit_zext;
        data_req.wdata = rs_data;
    end

    always_comb begin
        rf_wr.en   = (state == WRITEBACK) && writes_reg;
        rf_wr.addr = ir.rd;
        rf_wr.data = result;
    end

    assign fetch_addr = pc;
    assign rd_addr    = ir.rd;
    assign rs_addr    = ir.rs;
    assign rt_addr    = ir.rt;
    assign hlt        = (state == HALTED);

endmodule

/* rtl/tinker_core.sv */
// Tinker core top level connecting memory, register file and control
`timescale 1ns/100ps
`include "tinker_settings.svh"

module tinker_core import tinker_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    run,        // Level, sampled in IDLE
    input  logic                    host_we,
    input  logic [`TINKER_ALEN-1:0] host_addr,
    input  logic [`TINKER_XLEN-1:0] host_wdata,
    output logic [`TINKER_XLEN-1:0] host_rdata,
    output logic                    hlt
);

    logic [`TINKER_ALEN-1:0] fetch_addr;
    logic [`TINKER_ILEN-1:0] fetch_data;
    mem_req_t                data_req;
    logic [`TINKER_XLEN-1:0] data_rdata;
    reg_addr_t               rd_addr;
    reg_addr_t               rs_addr;
    reg_addr_t               rt_addr;
    logic [`TINKER_XLEN-1:0] rd_data;
    logic [`TINKER_XLEN-1:0] rs_data;
    logic [`TINKER_XLEN-1:0] rt_data;
    rf_write_t               rf_wr;

    tinker_memory tinker_memory_inst (
        .clk        (clk),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_data),
        .data_req   (data_req),
        .data_rdata (data_rdata),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata)
    );

    tinker_regfile tinker_regfile_inst (
        .clk     (clk),
        .reset   (reset),
        .wr      (rf_wr),
        .rd_addr (rd_addr),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .rd_data (rd_data),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    tinker_control tinker_control_inst (
        .clk        (clk),
        .reset      (reset),
        .run        (run),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_data),
        .rd_addr    (rd_addr),
        .rs_addr    (rs_addr),
        .rt_addr    (rt_addr),
        .rd_data    (rd_data),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .data_req   (data_req),
        .data_rdata (data_rdata),
        .rf_wr      (rf_wr),
        .hlt        (hlt)
    );

endmodule

/* tests/tinker_properties.sv */
// Concurrent assertions on the control FSM, halt flag, register write and store strobe
`timescale 1ns/100ps

module tinker_properties import tinker_pkg::*; (
    input logic       clk,
    input logic       reset,
    input fsm_state_e state,
    input logic       hlt,
    input rf_write_t  rf_wr,
    input mem_req_t   data_req
);

    int unsigned failures = 0;

    state_legal: assert property (@(posedge clk) disable iff (reset)
        state inside {IDLE, FETCH, DECODE, EXECUTE, MEMORY, WRITEBACK, HALTED})
        else begin
            $error("FSM state %0d is not a legal encoding", state);
            failures++;
        end

    // Only reset leaves HALTED
    hlt_sticky: assert property (@(posedge clk) disable iff (reset) hlt |=> hlt)
        else begin
            $error("hlt fell without reset");
            failures++;
        end

    rf_write_in_writeback: assert property (@(posedge clk) disable iff (reset)
        rf_wr.en |-> state == WRITEBACK)
        else begin
            $error("Register write outside WRITEBACK");
            failures++;
        end

    store_in_memory: assert property (@(posedge clk) disable iff (reset)
        data_req.we |-> state == MEMORY)
        else begin
            $error("Data store outside MEMORY");
            failures++;
        end

endmodule

bind tinker_control tinker_properties tinker_properties_inst (
    .clk      (clk),
    .reset    (reset),
    .state    (state),
    .hlt      (hlt),
    .rf_wr    (rf_wr),
    .data_req (data_req)
);

/* tests/tinker_tb.sv */
// Tinker core testbench with host loader, instruction encoder, LFSR, checks and directed tests
`timescale 1ns/100ps
`include "tinker_settings.svh"

module tinker_tb import tinker_pkg::*; ();

    localparam logic [31:0] SLOT_BASE = 32'h100; // Result words 8 bytes apart
    // About 140 instructions including halts plus 220 cycles of reset, loading and readback
    localparam int TIMEOUT_CYCLES = 2 * (5 * 140 + 220);

    logic                    clk;
    logic                    reset;
    logic                    run;
    logic                    host_we;
    logic [`TINKER_ALEN-1:0] host_addr;
    logic [`TINKER_XLEN-1:0] host_wdata;
    logic [`TINKER_XLEN-1:0] host_rdata;
    logic                    hlt;

    logic [31:0] prog [$];          // Program words from address 0x2000 upward
    logic [63:0] expected [$];      // One entry per result slot
    logic [31:0] lfsr = 32'hb07c_6f97;
    logic [31:0] target_reg;        // Value held in r9 by the branch test
    int          run_edges;
    int          cycles = 0;
    int unsigned assert_failures;

    assign assert_failures = tinker_core_inst.tinker_control_inst.tinker_properties_inst.failures;

    tinker_core tinker_core_inst (
        .clk        (clk),
        .reset      (reset),
        .run        (run),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata),
        .hlt        (hlt)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Watchdog and bound assertion monitor
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the core never reached halt", cycles);
            $display("TB FAILED");
            $fatal(1, "Simulation timed out");
        end else if (assert_failures != 0) begin
            $display("A bound assertion on the control unit failed");
            $display("TB FAILED");
            $fatal(1, "Assertion failure");
        end
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            bits = {bits[30:0], lfsr[0]};
        end
        return bits;
    endfunction

    function automatic logic [63:0] slot_fill(int k);
        logic [31:0] addr;
        addr = SLOT_BASE + 8 * k;
        return {~addr, addr};
    endfunction

    // Fields are opcode, rd, rs, rt and a 12-bit literal
    task automatic emit(opcode_e op, int rd, int rs, int rt, int lit);
        prog.push_back({op, rd[4:0], rs[4:0], rt[4:0], lit[11:0]});
    endtask

    // Base register r0 stays zero in every program
    task automatic store_slot(int rs, logic [63:0] want);
        emit(OP_STORE, 0, rs, 0, SLOT_BASE + 8 * expected.size());
        expected.push_back(want);
    endtask

    task automatic op_store(opcode_e op, int rd, int rs, int rt, int lit, logic [63:0] want);
        emit(op, rd, rs, rt, lit);
        store_slot(rd, want);
    endtask

    task automatic check(string name, logic [63:0] actual, logic [63:0] want);
        if (actual !== want) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, actual, want);
            $display("TB FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic host_write(logic [31:0] addr, logic [63:0] data);
        host_we    = 1'b1;
        host_addr  = addr;
        host_wdata = data;
        @(posedge clk);
        #1;
        host_we = 1'b0;
    endtask

    task automatic host_read(logic [31:0] addr, output logic [63:0] data);
        host_addr = addr;
        #2;
        data = host_rdata;
        @(posedge clk);
        #1;
    endtask

    task automatic reset_core();
        reset = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
    endtask

    // Two instructions per host write with the first at the lower address
    task automatic load_program();
        emit(OP_HALT, 0, 0, 0, 0);
        if (prog.size() % 2 != 0) begin
            emit(OP_HALT, 0, 0, 0, 0);
        end
        for (int i = 0; i < prog.size(); i += 2) begin
            host_write(`TINKER_RESET_PC + 4 * i, {prog[i + 1], prog[i]});
        end
        for (int k = 0; k < expected.size(); k++) begin
            host_write(SLOT_BASE + 8 * k, slot_fill(k));
        end
    endtask

    // Counts rising edges from raising run until hlt is seen
    task automatic run_to_halt();
        run = 1'b1;
        run_edges = 0;
        while (hlt !== 1'b1) begin
            @(posedge clk);
            #1;
            run_edges++;
        end
        run = 1'b0;
    endtask

    task automatic check_slots(string name);
        logic [63:0] word;
        for (int k = 0; k < expected.size(); k++) begin
            host_read(SLOT_BASE + 8 * k, word);
            check($sformatf("%s mem[%h]", name, SLOT_BASE + 8 * k), word, expected[k]);
        end
    endtask

    task automatic execute(string name);
        reset_core();
        load_program();
        run_to_halt();
        check_slots(name);
        prog.delete();
        expected.delete();
    endtask

    // Adds to r9 so that it points two instructions past the next one
    task automatic aim_r9();
        logic [31:0] target;
        target = `TINKER_RESET_PC + 4 * (prog.size() + 3);
        emit(OP_ADDI, 9, 0, 0, target - target_reg);
        target_reg = target;
    endtask

    task automatic test_reset_state();
        store_slot(0, 64'd0);
        store_slot(31, `TINKER_STACK_TOP);
        execute("reset state");
    endtask

    task automatic test_alu();
        logic [63:0] a;
        logic [63:0] b;
        a = (64'h7a5 << 44) + {{52{1'b1}}, 12'h9c3};
        b = 64'h0f3 - 64'hff0;
        emit(OP_MOVL, 1, 0, 0, 12'h7a5);
        emit(OP_SHFTLI, 1, 0, 0, 44);
        op_store(OP_ADDI, 1, 0, 0, 12'h9c3, a);    // Negative literal
        emit(OP_MOVL, 2, 0, 0, 12'h0f3);
        op_store(OP_SUBI, 2, 0, 0, 12'hff0, b);    // Literal taken as unsigned
        emit(OP_MOVL, 3, 0, 0, 5);
        op_store(OP_ADD, 4, 1, 2, 0, a + b);
        op_store(OP_SUB, 4, 1, 2, 0, a - b);
        op_store(OP_MUL, 4, 1, 2, 0, a * b);
        op_store(OP_AND, 4, 1, 2, 0, a & b);
        op_store(OP_OR, 4, 1, 2, 0, a | b);
        op_store(OP_XOR, 4, 1, 2, 0, a ^ b);
        op_store(OP_NOT, 4, 1, 0, 0, ~a);
        op_store(OP_SHFTR, 4, 1, 3, 0, a >> 5);
        op_store(OP_SHFTL, 4, 2, 3, 0, b << 5);
        emit(OP_MOV, 4, 2, 0, 0);
        op_store(OP_SHFTRI, 4, 0, 0, 7, b >> 7);   // Zero fill from the top
        op_store(OP_MOVL, 2, 0, 0, 12'habc, {b[63:12], 12'habc});
        execute("alu");
    endtask

    task automatic test_load_store();
        logic [63:0] word;
        host_write(32'h800, 64'h0123_4567_89ab_cdef);
        host_write(32'h808, 64'hdead_beef_0000_0808);
        emit(OP_MOVL, 5, 0, 0, 12'h7f8);           // Base address
        emit(OP_LOAD, 6, 5, 0, 8);
        emit(OP_MOV, 7, 6, 0, 0);
        emit(OP_STORE, 5, 7, 0, 12'h010);
        store_slot(6, 64'h0123_4567_89ab_cdef);
        execute("load store");
        host_read(32'h808, word);
        check("load store mem[808]", word, 64'h0123_4567_89ab_cdef);
    endtask

    // A taken branch skips a marker store and its slot keeps the fill word
    task automatic test_branches();
        emit(OP_MOVL, 8, 0, 0, 12'h111);           // Marker is non-zero and positive
        emit(OP_MOVL, 9, 0, 0, 2);
        emit(OP_SHFTLI, 9, 0, 0, 12);              // r9 = 0x2000
        emit(OP_MOVL, 11, 0, 0, 8);                // Offset over one instruction
        emit(OP_SUBI, 12, 0, 0, 1);                // r12 = -1
        target_reg = `TINKER_RESET_PC;
        aim_r9();
        emit(OP_BR, 9, 0, 0, 0);
        store_slot(8, slot_fill(expected.size()));
        emit(OP_BRR_R, 11, 0, 0, 0);
        store_slot(8, slot_fill(expected.size()));
        emit(OP_BRR_L, 0, 0, 0, 8);
        store_slot(8, slot_fill(expected.size()));
        aim_r9();
        emit(OP_BRNZ, 9, 8, 0, 0);
        store_slot(8, slot_fill(expected.size()));
        aim_r9();
        emit(OP_BRNZ, 9, 0, 0, 0);                 // r0 is zero so it falls through
        store_slot(8, 64'h111);
        aim_r9();
        emit(OP_BRGT, 9, 8, 12, 0);                // Signed 0x111 > -1
        store_slot(8, slot_fill(expected.size()));
        aim_r9();
        emit(OP_BRGT, 9, 12, 8, 0);
        store_slot(8, 64'h111);
        execute("branches");
    endtask

    task automatic test_halt_timing();
        int n;
        for (int i = 1; i <= 6; i++) begin
            emit(OP_ADDI, 13, 0, 0, i);
        end
        store_slot(13, 64'd21);
        n = prog.size();
        execute("halt timing");
        check("edges from run to hlt", run_edges, 5 * n + 3);
        repeat (20) begin
            @(posedge clk);
            #1;
            check("hlt", hlt, 1'b1);
        end
    endtask

    task automatic test_random_operands();
        logic [11:0] l1;
        logic [11:0] l2;
        logic [5:0]  sh;
        logic [63:0] x;
        logic [63:0] y;
        repeat (4) begin
            l1 = 12'(take_bits(12));
            l2 = 12'(take_bits(12));
            sh = 6'(take_bits(6));
            x  = {52'd0, l1};
            y  = {{52{l2[11]}}, l2};
            emit(OP_MOVL, 14, 0, 0, l1);
            emit(OP_ADDI, 15, 0, 0, l2);           // From zero after reset
            emit(OP_MOVL, 16, 0, 0, sh);
            op_store(OP_ADD, 17, 14, 15, 0, x + y);
            op_store(OP_SUB, 17, 14, 15, 0, x - y);
            op_store(OP_XOR, 17, 14, 15, 0, x ^ y);
            op_store(OP_SHFTL, 17, 15, 16, 0, y << sh);
            op_store(OP_SHFTR, 17, 15, 16, 0, y >> sh);
            op_store(OP_SHFTLI, 14, 0, 0, sh, x << sh);
            execute("random operands");
        end
    endtask

    initial begin
        reset      = 1'b1;
        run        = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        test_reset_state();
        test_alu();
        test_load_store();
        test_branches();
        test_halt_timing();
        test_random_operands();
        @(posedge clk);
        #1;
        if (assert_failures != 0) begin
            $display("A bound assertion on the control unit failed");
            $display("TB FAILED");
            $fatal(1, "Assertion failure");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

/* filelist.f */
+incdir+rtl
rtl/tinker_pkg.sv
rtl/tinker_alu.sv
rtl/tinker_regfile.sv
rtl/tinker_memory.sv
rtl/tinker_control.sv
rtl/tinker_core.sv
tests/tinker_properties.sv
tests/tinker_tb.sv

/* Bender.yml */
package:
  name: tinker

export_include_dirs:
  - rtl

sources:
  - rtl/tinker_pkg.sv
  - rtl/tinker_alu.sv
  - rtl/tinker_regfile.sv
  - rtl/tinker_memory.sv
  - rtl/tinker_control.sv
  - rtl/tinker_core.sv
  - target: test
    files:
      - tests/tinker_properties.sv
      - tests/tinker_tb.sv
